//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_seg_display
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- digit_source.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module digit_source (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load,
  input  seg_display_pkg::display_word_t word,
  input  seg_display_pkg::digit_sel_t    sel,
  output seg_display_pkg::segments_t     seg_raw
);

  import seg_display_pkg::*;

  display_word_t word_q;
  nibble_t       nibble;

  // Word register, new value shows from the cycle after load
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word_q <= '0;
    end
    else if (load)
    begin
      word_q <= word;
    end
  end

  assign nibble = word_q[{sel, 2'b00} +: 4];

  // Hex to seven segments, active low, a in bit 0
  always_comb
  begin
    case (nibble)
      4'h0:    seg_raw = 7'h40;
      4'h1:    seg_raw = 7'h79;
      4'h2:    seg_raw = 7'h24;
      4'h3:    seg_raw = 7'h30;
      4'h4:    seg_raw = 7'h19;
      4'h5:    seg_raw = 7'h12;
      4'h6:    seg_raw = 7'h02;
      4'h7:    seg_raw = 7'h78;
      4'h8:    seg_raw = 7'h00;
      4'h9:    seg_raw = 7'h10;
      4'hA:    seg_raw = 7'h08;
      4'hB:    seg_raw = 7'h03; // Lower case b
      4'hC:    seg_raw = 7'h46;
      4'hD:    seg_raw = 7'h21; // Lower case d
      4'hE:    seg_raw = 7'h06;
      4'hF:    seg_raw = 7'h0E;
      default: seg_raw = `SEG_BLANK;
    endcase
  end

endmodule

//--- led_state_driver.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module led_state_driver (
  input  seg_display_pkg::refresh_state_t state,
  output seg_display_pkg::digit_sel_t     sel,
  output seg_display_pkg::anodes_t        anodes_raw
);

  import seg_display_pkg::*;

  refresh_phase_t phase;

  // Upper bits pick the digit, lower bits the phase within it
  assign sel   = digit_sel_t'(state[3:2]);
  assign phase = refresh_phase_t'(state[1:0]);

  // Only PH_ON lights an anode, the other three phases are guard time.
  // The digit source already sees sel during PH_LEAD and PH_PREP, so the
  // segment pattern has settled before the anode turns on.
  always_comb
  begin
    anodes_raw = `SEG_ANODES_OFF;
    unique case (phase)
      PH_LEAD:
      begin
        anodes_raw = `SEG_ANODES_OFF;
      end
      PH_PREP:
      begin
        anodes_raw = `SEG_ANODES_OFF;
      end
      PH_ON:
      begin
        for (int k = 0; k < `SEG_DIGITS; k++)
        begin
          anodes_raw[k] = (sel != digit_sel_t'(k)); // Active low
        end
      end
      PH_TAIL:
      begin
        anodes_raw = `SEG_ANODES_OFF;
      end
      default:
      begin
        anodes_raw = `SEG_ANODES_OFF;
      end
    endcase
  end

endmodule

//--- seg_display_params.svh
`ifndef SEG_DISPLAY_PARAMS_SVH
`define SEG_DISPLAY_PARAMS_SVH

// Clock cycles spent in each refresh state
`define SEG_PRESCALE_DEFAULT 4

// Digits on the display
`define SEG_DIGITS 4

// Anodes and segments are active low
`define SEG_ANODES_OFF {`SEG_DIGITS{1'b1}}
`define SEG_BLANK 7'h7F

`endif

//--- seg_display_pkg.sv
`include "seg_display_params.svh"

package seg_display_pkg;

  // Refresh counter, four states per digit
  typedef logic [3:0] refresh_state_t;

  typedef logic [$clog2(`SEG_DIGITS)-1:0] digit_sel_t;

  typedef logic [3:0] nibble_t;

  // Bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] segments_t;

  typedef logic [`SEG_DIGITS-1:0] anodes_t;

  // Digit 0 in the low nibble
  typedef logic [4*`SEG_DIGITS-1:0] display_word_t;

  // Low two bits of the refresh state
  typedef enum logic [1:0]
  {
    PH_LEAD = 2'd0,
    PH_PREP = 2'd1,
    PH_ON   = 2'd2,
    PH_TAIL = 2'd3
  } refresh_phase_t;

endpackage

//--- seg_display_top.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module seg_display_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load,
  input  seg_display_pkg::display_word_t word,
  output seg_display_pkg::anodes_t       an,
  output seg_display_pkg::segments_t     seg
);

  import seg_display_pkg::*;

  refresh_state_t state;
  digit_sel_t     sel;
  anodes_t        anodes_raw;
  segments_t      seg_raw;

  seg_refresh_timer #(
    .PRESCALE (`SEG_PRESCALE_DEFAULT)
  ) u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .state (state)
  );

  // Combinational decode of the refresh state
  led_state_driver u_driver (
    .state      (state),
    .sel        (sel),
    .anodes_raw (anodes_raw)
  );

  digit_source u_digits (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .word    (word),
    .sel     (sel),
    .seg_raw (seg_raw)
  );

  // Pins are registered here
  seg_output_stage u_out (
    .clk        (clk),
    .rst_n      (rst_n),
    .anodes_raw (anodes_raw),
    .seg_raw    (seg_raw),
    .an         (an),
    .seg        (seg)
  );

endmodule

//--- seg_output_stage.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module seg_output_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  seg_display_pkg::anodes_t   anodes_raw,
  input  seg_display_pkg::segments_t seg_raw,
  output seg_display_pkg::anodes_t   an,
  output seg_display_pkg::segments_t seg
);

  import seg_display_pkg::*;

  logic     all_off;
  segments_t seg_next;

  assign all_off  = (anodes_raw == `SEG_ANODES_OFF);
  assign seg_next = all_off ? `SEG_BLANK : seg_raw; // Dark between digits

  // Both paths share one register stage so they stay aligned
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      an  <= `SEG_ANODES_OFF;
      seg <= `SEG_BLANK;
    end
    else
    begin
      an  <= anodes_raw;
      seg <= seg_next;
    end
  end

  // Never two digits driven at once
  a_one_anode: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(~an));

  a_blank_when_dark: assert property (@(posedge clk) disable iff (!rst_n)
    (an == `SEG_ANODES_OFF) |-> (seg == `SEG_BLANK));

endmodule

//--- seg_refresh_timer.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module seg_refresh_timer #(
  parameter int PRESCALE = `SEG_PRESCALE_DEFAULT
) (
  input  logic                            clk,
  input  logic                            rst_n,
  output seg_display_pkg::refresh_state_t state
);

  import seg_display_pkg::*;

  // Keep at least one bit for PRESCALE of 1
  localparam int CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

  logic [CW-1:0] pre_cnt;
  logic          wrap;

  assign wrap = (pre_cnt == CW'(PRESCALE - 1));

  // Prescaler
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pre_cnt <= '0;
    end
    else if (wrap)
    begin
      pre_cnt <= '0;
    end
    else
    begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // State steps once per prescaler wrap, 15 rolls over to 0
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= '0;
    end
    else if (wrap)
    begin
      state <= refresh_state_t'(state + 1'b1);
    end
  end

  a_prescale_min: assert property (@(posedge clk) PRESCALE >= 1);

  a_step_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(state) |-> $past(wrap));

endmodule

//--- sources.f
+incdir+.
seg_display_pkg.sv
seg_refresh_timer.sv
led_state_driver.sv
digit_source.sv
seg_output_stage.sv
seg_display_top.sv
tb_seg_display.sv

//--- tb_seg_display.sv
`timescale 1ns/1ps
`include "seg_display_params.svh"

module tb_seg_display;

  import seg_display_pkg::*;

  localparam int PRESCALE = `SEG_PRESCALE_DEFAULT;
  localparam int REFRESH  = 16 * PRESCALE; // Cycles per full refresh
  localparam int N_RAND   = 24;
  localparam int TIMEOUT_CYCLES = 8 + (2 * REFRESH + 4) + (REFRESH + 4) + 4 * (REFRESH + 6)
                                  + N_RAND * (REFRESH + 70) + REFRESH + 100;

  logic          clk;
  logic          rst_n;
  logic          load;
  display_word_t word;
  anodes_t       an;
  segments_t     seg;

  int            edges = 0; // Rising edges since reset release
  display_word_t word_model = '0;
  display_word_t shown_word = '0; // Register value behind the current pins
  logic [10:0]   exp_pins;
  int            lit_count [4];
  int            dark_count = 0;
  int            error_count = 0;
  int            errors_at_start = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            cycle_count = 0;
  logic [31:0]   lfsr = 32'h942d8acd;
  display_word_t hex_words [4] = '{16'h0123, 16'h4567, 16'h89AB, 16'hCDEF};

  seg_display_top u_seg_display_top (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .word  (word),
    .an    (an),
    .seg   (seg)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = next_lfsr(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // Glyphs active high with a in bit 0, pins are the inverse
  function automatic segments_t hex_pattern(input nibble_t value);
    segments_t lit;
    case (value)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      4'hF: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic nibble_t nibble_of(input display_word_t w, input logic [1:0] d);
    return 4'(w >> {d, 2'b00});
  endfunction

  // Expected {an, seg} after e rising edges, pins trail the state by one edge
  function automatic logic [10:0] expected_pins(input int e, input display_word_t shown);
    int        s;
    anodes_t   anodes;
    segments_t segs;
    anodes = `SEG_ANODES_OFF;
    segs   = `SEG_BLANK;
    if (e >= 1)
    begin
      s = ((e - 1) / PRESCALE) % 16;
      if (s % 4 == 2)
      begin
        anodes[2'(s / 4)] = 1'b0;
        segs = hex_pattern(nibble_of(shown, 2'(s / 4)));
      end
    end
    return {anodes, segs};
  endfunction

  function automatic bit window_start(input int e);
    return (e >= 1) && (((e - 1) / PRESCALE) % 4 == 2) && ((e - 1) % PRESCALE == 0);
  endfunction

  function automatic logic [1:0] window_digit(input int e);
    return 2'(((e - 1) / PRESCALE / 4) % 4);
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic clear_counts();
    for (int k = 0; k < 4; k++)
    begin
      lit_count[2'(k)] = 0;
    end
    dark_count = 0;
  endtask

  task automatic start_test();
    @(posedge clk);
    errors_at_start = error_count;
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    tests_run++;
    if (error_count == errors_at_start)
    begin
      $display("Test %0d (%s) done, no errors", tests_run, name);
    end
    else
    begin
      tests_failed++;
      $display("Test %0d (%s) done, %0d errors", tests_run, name,
               error_count - errors_at_start);
    end
  endtask

  // Drives from the current falling edge
  task automatic strobe_load(input display_word_t w);
    word = w;
    load = 1'b1;
    @(negedge clk);
    load = 1'b0;
  endtask

  task automatic load_word(input display_word_t w);
    @(negedge clk);
    strobe_load(w);
  endtask

  task automatic wait_window_start();
    @(negedge clk);
    while (!window_start(edges))
    begin
      @(negedge clk);
    end
  endtask

  // Reference state, advanced on each rising edge
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      edges      = 0;
      word_model = '0;
      shown_word = '0;
    end
    else
    begin
      shown_word = word_model;
      if (load)
      begin
        word_model = word;
      end
      edges++;
    end
  end

  always @(negedge clk)
  begin
    exp_pins = expected_pins(edges, shown_word);
    check_value("an", 32'(an), 32'(exp_pins[10:7]));
    check_value("seg", 32'(seg), 32'(exp_pins[6:0]));
    check_value("at most one anode low", 32'($countones(~an) <= 1), 32'd1);
    if (an == `SEG_ANODES_OFF)
    begin
      dark_count++;
      check_value("seg while dark", 32'(seg), 32'(`SEG_BLANK));
    end
    for (int k = 0; k < 4; k++)
    begin
      if (!an[2'(k)])
      begin
        lit_count[2'(k)]++;
      end
    end
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    display_word_t w;
    display_word_t old_word;
    logic [1:0]    digit;
    int            gap;
    rst_n     = 1'b0;
    load      = 1'b0;
    word      = '0;
    clear_counts();

    start_test();
    repeat (2) @(negedge clk);
    check_value("an during reset", 32'(an), 32'(`SEG_ANODES_OFF));
    check_value("seg during reset", 32'(seg), 32'(`SEG_BLANK));
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("an after release", 32'(an), 32'(`SEG_ANODES_OFF));
    check_value("seg after release", 32'(seg), 32'(`SEG_BLANK));
    finish_test("reset state");

    start_test();
    load_word(16'h1234);
    @(posedge clk);
    clear_counts();
    repeat (2 * REFRESH) @(posedge clk);
    for (int k = 0; k < 4; k++)
    begin
      check_value($sformatf("lit cycles of anode %0d", k), 32'(lit_count[2'(k)]),
                  32'(2 * PRESCALE));
    end
    finish_test("refresh sequence");

    start_test();
    load_word(16'h8888); // All segments on
    @(posedge clk);
    clear_counts();
    repeat (REFRESH) @(posedge clk);
    check_value("dark cycles per refresh", 32'(dark_count), 32'(12 * PRESCALE));
    finish_test("blanking");

    start_test();
    for (int i = 0; i < 4; i++)
    begin
      load_word(hex_words[2'(i)]);
      @(posedge clk);
      clear_counts();
      repeat (REFRESH) @(posedge clk);
      for (int k = 0; k < 4; k++)
      begin
        check_value($sformatf("lit cycles of digit %0d", k), 32'(lit_count[2'(k)]),
                    32'(PRESCALE));
      end
    end
    finish_test("hex decoding");

    start_test();
    for (int i = 0; i < N_RAND; i++)
    begin
      w = 16'(rand_bits(16));
      if (i % 2 == 1)
      begin
        // Strobe in the first lit cycle of a digit
        wait_window_start();
        digit    = window_digit(edges);
        old_word = word_model;
        strobe_load(w);
        if (PRESCALE >= 3)
        begin
          check_value("seg one cycle after load", 32'(seg),
                      32'(hex_pattern(nibble_of(old_word, digit))));
          @(negedge clk);
          check_value("seg two cycles after load", 32'(seg),
                      32'(hex_pattern(nibble_of(w, digit))));
        end
      end
      else
      begin
        gap = 1 + int'(rand_bits(6));
        repeat (gap) @(negedge clk);
        strobe_load(w);
      end
    end
    repeat (REFRESH) @(negedge clk);
    finish_test("random loads");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
